//--- common/nes_core_config.svh
// NES core control configuration
// bridge register map, field widths, counter lengths and the
// PLL management table for NTSC and PAL clocking

`ifndef NES_CORE_CONFIG_SVH
`define NES_CORE_CONFIG_SVH

//////////////////////////////////////////////////
// bridge bus

`define BRIDGE_ADDR_W 32
`define BRIDGE_DATA_W 32

`define ADDR_SOFT_RESET    32'h0000_0050
`define ADDR_REGION        32'h0000_0054
`define ADDR_HIDE_OVERSCAN 32'h0000_0200
`define ADDR_MASK_EDGES    32'h0000_0204
`define ADDR_EXTRA_SPRITES 32'h0000_0208
`define ADDR_PALETTE       32'h0000_020C
`define ADDR_MULTITAP      32'h0000_0300
`define ADDR_LIGHTGUN      32'h0000_0304
`define ADDR_AIM_SPEED     32'h0000_0308
`define ADDR_SWAP_CONT     32'h0000_030C

// settings field widths
`define REGION_W    2
`define EDGE_MASK_W 2
`define PALETTE_W   3
`define AIM_SPEED_W 8

// core reset hold after a soft reset request
`define SOFT_RESET_CYCLES 32'h0010_0000
`define SOFT_RESET_CNT_W  21

//////////////////////////////////////////////////
// PLL management port

`define CFG_ADDR_W 6
`define CFG_DATA_W 32
`define CFG_STEPS  8
`define CFG_STEP_W 4

// mode register
`define CFG_ADDR_STEP0 6'd0
`define CFG_NTSC_STEP0 32'd0
`define CFG_PAL_STEP0  32'd0
// fractional divider
`define CFG_ADDR_STEP1 6'd7
`define CFG_NTSC_STEP1 32'd425907062
`define CFG_PAL_STEP1  32'd737738000
// counter C0
`define CFG_ADDR_STEP2 6'd5
`define CFG_NTSC_STEP2 32'h0002_0403
`define CFG_PAL_STEP2  32'h0000_0404
// counter C1
`define CFG_ADDR_STEP3 6'd5
`define CFG_NTSC_STEP3 32'h0004_0E0E
`define CFG_PAL_STEP3  32'h0004_1010
// counter C2
`define CFG_ADDR_STEP4 6'd5
`define CFG_NTSC_STEP4 32'h0008_3838
`define CFG_PAL_STEP4  32'h0008_4040
// counter C3
`define CFG_ADDR_STEP5 6'd5
`define CFG_NTSC_STEP5 32'h000C_3838
`define CFG_PAL_STEP5  32'h000C_4040
// counter M
`define CFG_ADDR_STEP6 6'd4
`define CFG_NTSC_STEP6 32'h0000_0404
`define CFG_PAL_STEP6  32'h0002_0504
// start reconfiguration
`define CFG_ADDR_STEP7 6'd2
`define CFG_NTSC_STEP7 32'd0
`define CFG_PAL_STEP7  32'd0

`endif

//--- common/nes_core_pkg.sv
// NES core control types
// shared by the settings bank, the PLL sequencer and the reset controller

`include "nes_core_config.svh"

package nes_core_pkg;

  //////////////////////////////////////////////////
  // bridge bus words

  typedef logic [`BRIDGE_ADDR_W-1:0] bridge_addr_t;
  typedef logic [`BRIDGE_DATA_W-1:0] bridge_data_t;

  //////////////////////////////////////////////////
  // settings fields

  // zero is NTSC, anything else runs PAL timing
  typedef logic [`REGION_W-1:0] region_t;

  typedef logic [`PALETTE_W-1:0]   palette_t;
  typedef logic [`EDGE_MASK_W-1:0] edge_mask_t;
  typedef logic [`AIM_SPEED_W-1:0] aim_speed_t;

  // soft reset hold counter
  typedef logic [`SOFT_RESET_CNT_W-1:0] hold_cnt_t;

  //////////////////////////////////////////////////
  // PLL management port

  typedef logic [`CFG_ADDR_W-1:0] cfg_addr_t;
  typedef logic [`CFG_DATA_W-1:0] cfg_data_t;

  // step index, room for all steps plus idle
  typedef logic [`CFG_STEP_W-1:0] cfg_step_t;

  // sequencer FSM
  typedef enum logic [1:0] {
    SEQ_IDLE  = 2'd0,
    SEQ_ISSUE = 2'd1,
    SEQ_GAP   = 2'd2
  } seq_state_t;

endpackage

//--- settings/settings_regs.sv
// Settings register bank
// decodes bridge writes into region, video and input settings,
// and turns a soft reset write into a one-cycle request

`include "nes_core_config.svh"

module settings_regs (
  input  logic                       clk_74a,
  input  logic                       pll_core_locked,
  input  nes_core_pkg::bridge_addr_t bridge_addr,
  input  logic                       bridge_wr,
  input  nes_core_pkg::bridge_data_t bridge_wr_data,
  output nes_core_pkg::region_t      region,
  output logic                       hide_overscan,
  output nes_core_pkg::edge_mask_t   mask_vid_edges,
  output logic                       allow_extra_sprites,
  output nes_core_pkg::palette_t     selected_palette,
  output logic                       multitap_enabled,
  output logic                       lightgun_enabled,
  output nes_core_pkg::aim_speed_t   lightgun_aim_speed,
  output logic                       swap_controllers,
  output logic                       soft_reset_req
);
  import nes_core_pkg::*;

  //////////////////////////////////////////////////
  // register writes, full address decode

  always_ff @(posedge clk_74a or negedge pll_core_locked) begin
    if (!pll_core_locked) begin
      region              <= '0;
      hide_overscan       <= 1'b0;
      mask_vid_edges      <= '0;
      allow_extra_sprites <= 1'b0;
      selected_palette    <= '0;
      multitap_enabled    <= 1'b0;
      lightgun_enabled    <= 1'b0;
      lightgun_aim_speed  <= '0;
      swap_controllers    <= 1'b0;
      soft_reset_req      <= 1'b0;
    end else begin
      // request is a single pulse
      soft_reset_req <= 1'b0;

      if (bridge_wr) begin
        case (bridge_addr)
          `ADDR_SOFT_RESET: begin
            // data is don't care here
            soft_reset_req <= 1'b1;
          end
          `ADDR_REGION: begin
            region <= region_t'(bridge_wr_data[`REGION_W-1:0]);
          end
          `ADDR_HIDE_OVERSCAN: begin
            hide_overscan <= bridge_wr_data[0];
          end
          `ADDR_MASK_EDGES: begin
            mask_vid_edges <= edge_mask_t'(bridge_wr_data[`EDGE_MASK_W-1:0]);
          end
          `ADDR_EXTRA_SPRITES: begin
            allow_extra_sprites <= bridge_wr_data[0];
          end
          `ADDR_PALETTE: begin
            selected_palette <= palette_t'(bridge_wr_data[`PALETTE_W-1:0]);
          end
          `ADDR_MULTITAP: begin
            multitap_enabled <= bridge_wr_data[0];
          end
          `ADDR_LIGHTGUN: begin
            lightgun_enabled <= bridge_wr_data[0];
          end
          `ADDR_AIM_SPEED: begin
            lightgun_aim_speed <= aim_speed_t'(bridge_wr_data[`AIM_SPEED_W-1:0]);
          end
          `ADDR_SWAP_CONT: begin
            swap_controllers <= bridge_wr_data[0];
          end
          default: begin
            // unmapped address, nothing to store
          end
        endcase
      end
    end
  end

endmodule

//--- pll_reconfig/pll_reconfig_seq.sv
// PLL reconfiguration sequencer
// watches for NTSC/PAL mode changes and writes the eight-step
// management table to the PLL, pacing each write against waitrequest

`include "nes_core_config.svh"

module pll_reconfig_seq (
  input  logic                    clk_74a,
  input  logic                    pll_core_locked,
  input  nes_core_pkg::region_t   region,
  input  logic                    cfg_waitrequest,
  output logic                    cfg_write,
  output nes_core_pkg::cfg_addr_t cfg_address,
  output nes_core_pkg::cfg_data_t cfg_data,
  output logic                    reconfig_busy
);
  import nes_core_pkg::*;

  logic       pal_mode;
  logic       pal_mode_d;
  logic       mode_change;
  logic       write_pal;
  logic       last_step;
  seq_state_t state;
  cfg_step_t  step;
  cfg_data_t  ntsc_data;
  cfg_data_t  pal_data;

  //////////////////////////////////////////////////
  // mode tracking

  always_ff @(posedge clk_74a or negedge pll_core_locked) begin
    if (!pll_core_locked) begin
      pal_mode   <= 1'b0;
      pal_mode_d <= 1'b0;
    end else begin
      pal_mode   <= region != '0;
      pal_mode_d <= pal_mode;
    end
  end

  // high for one cycle after each switch
  assign mode_change = pal_mode != pal_mode_d;

  assign last_step = step == cfg_step_t'(`CFG_STEPS - 1);

  //////////////////////////////////////////////////
  // step FSM

  always_ff @(posedge clk_74a or negedge pll_core_locked) begin
    if (!pll_core_locked) begin
      state     <= SEQ_IDLE;
      step      <= '0;
      write_pal <= 1'b0;
    end else if (mode_change) begin
      // a new change always restarts from the top of the table
      state     <= SEQ_ISSUE;
      step      <= '0;
      write_pal <= pal_mode;
    end else begin
      case (state)
        SEQ_ISSUE: begin
          // write goes out and is taken only while waitrequest is low
          if (!cfg_waitrequest) begin
            if (last_step) begin
              state <= SEQ_IDLE;
            end else begin
              state <= SEQ_GAP;
              step  <= step + 1'b1;
            end
          end
        end
        SEQ_GAP: begin
          state <= SEQ_ISSUE;
        end
        default: begin
          state <= SEQ_IDLE;
        end
      endcase
    end
  end

  assign cfg_write     = (state == SEQ_ISSUE) && !cfg_waitrequest;
  assign reconfig_busy = state != SEQ_IDLE;

  //////////////////////////////////////////////////
  // management table

  always_comb begin
    case (step)
      cfg_step_t'(0): begin
        cfg_address = `CFG_ADDR_STEP0;
        ntsc_data   = `CFG_NTSC_STEP0;
        pal_data    = `CFG_PAL_STEP0;
      end
      cfg_step_t'(1): begin
        cfg_address = `CFG_ADDR_STEP1;
        ntsc_data   = `CFG_NTSC_STEP1;
        pal_data    = `CFG_PAL_STEP1;
      end
      cfg_step_t'(2): begin
        cfg_address = `CFG_ADDR_STEP2;
        ntsc_data   = `CFG_NTSC_STEP2;
        pal_data    = `CFG_PAL_STEP2;
      end
      cfg_step_t'(3): begin
        cfg_address = `CFG_ADDR_STEP3;
        ntsc_data   = `CFG_NTSC_STEP3;
        pal_data    = `CFG_PAL_STEP3;
      end
      cfg_step_t'(4): begin
        cfg_address = `CFG_ADDR_STEP4;
        ntsc_data   = `CFG_NTSC_STEP4;
        pal_data    = `CFG_PAL_STEP4;
      end
      cfg_step_t'(5): begin
        cfg_address = `CFG_ADDR_STEP5;
        ntsc_data   = `CFG_NTSC_STEP5;
        pal_data    = `CFG_PAL_STEP5;
      end
      cfg_step_t'(6): begin
        cfg_address = `CFG_ADDR_STEP6;
        ntsc_data   = `CFG_NTSC_STEP6;
        pal_data    = `CFG_PAL_STEP6;
      end
      default: begin
        // final step kicks off the reconfiguration
        cfg_address = `CFG_ADDR_STEP7;
        ntsc_data   = `CFG_NTSC_STEP7;
        pal_data    = `CFG_PAL_STEP7;
      end
    endcase
  end

  // data follows the mode latched at sequence start
  assign cfg_data = write_pal ? pal_data : ntsc_data;

endmodule

//--- source/core_reset_ctrl.sv
// Core reset controller
// stretches a soft reset request into a long hold and merges it
// with PLL reconfiguration busy into one registered core reset

`include "nes_core_config.svh"

module core_reset_ctrl (
  input  logic clk_74a,
  input  logic pll_core_locked,
  input  logic soft_reset_req,
  input  logic reconfig_busy,
  output logic core_reset
);
  import nes_core_pkg::*;

  hold_cnt_t hold_cnt;

  //////////////////////////////////////////////////
  // soft reset hold

  always_ff @(posedge clk_74a or negedge pll_core_locked) begin
    if (!pll_core_locked) begin
      hold_cnt <= '0;
    end else if (soft_reset_req) begin
      // a repeat request starts the hold over
      hold_cnt <= hold_cnt_t'(`SOFT_RESET_CYCLES);
    end else if (hold_cnt != '0) begin
      hold_cnt <= hold_cnt - 1'b1;
    end
  end

  // clocks are moving while the PLL rewrites, keep the core parked
  always_ff @(posedge clk_74a or negedge pll_core_locked) begin
    if (!pll_core_locked) begin
      core_reset <= 1'b0;
    end else begin
      core_reset <= (hold_cnt != '0) || reconfig_busy;
    end
  end

endmodule

//--- source/core_control_top.sv
// NES core control top level
// settings bank and PLL sequencer side by side, with the reset
// controller combining soft reset and reconfiguration busy

module core_control_top (
  input  logic                       clk_74a,
  input  logic                       pll_core_locked,
  input  nes_core_pkg::bridge_addr_t bridge_addr,
  input  logic                       bridge_wr,
  input  nes_core_pkg::bridge_data_t bridge_wr_data,
  input  logic                       cfg_waitrequest,
  output nes_core_pkg::region_t      region,
  output logic                       hide_overscan,
  output nes_core_pkg::edge_mask_t   mask_vid_edges,
  output logic                       allow_extra_sprites,
  output nes_core_pkg::palette_t     selected_palette,
  output logic                       multitap_enabled,
  output logic                       lightgun_enabled,
  output nes_core_pkg::aim_speed_t   lightgun_aim_speed,
  output logic                       swap_controllers,
  output logic                       cfg_write,
  output nes_core_pkg::cfg_addr_t    cfg_address,
  output nes_core_pkg::cfg_data_t    cfg_data,
  output logic                       core_reset
);

  logic soft_reset_req;
  logic reconfig_busy;

  settings_regs settings_regs0 (
    .clk_74a             (clk_74a),
    .pll_core_locked     (pll_core_locked),
    .bridge_addr         (bridge_addr),
    .bridge_wr           (bridge_wr),
    .bridge_wr_data      (bridge_wr_data),
    .region              (region),
    .hide_overscan       (hide_overscan),
    .mask_vid_edges      (mask_vid_edges),
    .allow_extra_sprites (allow_extra_sprites),
    .selected_palette    (selected_palette),
    .multitap_enabled    (multitap_enabled),
    .lightgun_enabled    (lightgun_enabled),
    .lightgun_aim_speed  (lightgun_aim_speed),
    .swap_controllers    (swap_controllers),
    .soft_reset_req      (soft_reset_req)
  );

  // region also feeds the sequencer
  pll_reconfig_seq pll_reconfig_seq0 (
    .clk_74a         (clk_74a),
    .pll_core_locked (pll_core_locked),
    .region          (region),
    .cfg_waitrequest (cfg_waitrequest),
    .cfg_write       (cfg_write),
    .cfg_address     (cfg_address),
    .cfg_data        (cfg_data),
    .reconfig_busy   (reconfig_busy)
  );

  core_reset_ctrl core_reset_ctrl0 (
    .clk_74a         (clk_74a),
    .pll_core_locked (pll_core_locked),
    .soft_reset_req  (soft_reset_req),
    .reconfig_busy   (reconfig_busy),
    .core_reset      (core_reset)
  );

endmodule

//--- tb/tb_core_control.sv
// NES core control testbench
// random bridge writes and region switches checked against a shadow model,
// with a PLL management responder and soft reset hold timing

`include "nes_core_config.svh"

module tb_core_control;
  timeunit 1ns;
  timeprecision 100ps;
  import nes_core_pkg::*;

  logic         clk_74a = 1'b0;
  logic         pll_core_locked;
  bridge_addr_t bridge_addr;
  logic         bridge_wr;
  bridge_data_t bridge_wr_data;
  logic         cfg_waitrequest;
  region_t      region;
  logic         hide_overscan;
  edge_mask_t   mask_vid_edges;
  logic         allow_extra_sprites;
  palette_t     selected_palette;
  logic         multitap_enabled;
  logic         lightgun_enabled;
  aim_speed_t   lightgun_aim_speed;
  logic         swap_controllers;
  logic         cfg_write;
  cfg_addr_t    cfg_address;
  cfg_data_t    cfg_data;
  logic         core_reset;

  // shadow settings
  region_t    m_region;
  logic       m_hide;
  edge_mask_t m_mask;
  logic       m_sprites;
  palette_t   m_palette;
  logic       m_multitap;
  logic       m_lightgun;
  aim_speed_t m_aim;
  logic       m_swap;

  // accepted management writes
  logic      wait_enable;
  cfg_addr_t log_addr[$];
  cfg_data_t log_data[$];
  logic      log_reset[$];

  core_control_top dut0 (.*);

  always #4 clk_74a = ~clk_74a;

  //////////////////////////////////////////////////
  // checks and reference tables

  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    if (actual !== expected) begin
      $display("Fail %s: actual %h expected %h", name, actual, expected);
      $display("Simulation failed");
      $fatal(1);
    end
  endtask

  task automatic report_timeout(input string what);
    $display("Timeout: %s", what);
    $display("Simulation failed");
    $fatal(1);
  endtask

  function automatic bridge_addr_t setting_addr(input int idx);
    case (idx)
      0: setting_addr = `ADDR_REGION;
      1: setting_addr = `ADDR_HIDE_OVERSCAN;
      2: setting_addr = `ADDR_MASK_EDGES;
      3: setting_addr = `ADDR_EXTRA_SPRITES;
      4: setting_addr = `ADDR_PALETTE;
      5: setting_addr = `ADDR_MULTITAP;
      6: setting_addr = `ADDR_LIGHTGUN;
      7: setting_addr = `ADDR_AIM_SPEED;
      default: setting_addr = `ADDR_SWAP_CONT;
    endcase
  endfunction

  function automatic cfg_addr_t table_addr(input int step);
    case (step)
      0: table_addr = `CFG_ADDR_STEP0;
      1: table_addr = `CFG_ADDR_STEP1;
      2: table_addr = `CFG_ADDR_STEP2;
      3: table_addr = `CFG_ADDR_STEP3;
      4: table_addr = `CFG_ADDR_STEP4;
      5: table_addr = `CFG_ADDR_STEP5;
      6: table_addr = `CFG_ADDR_STEP6;
      default: table_addr = `CFG_ADDR_STEP7;
    endcase
  endfunction

  function automatic cfg_data_t table_data(input int step, input logic pal);
    case (step)
      0: table_data = pal ? `CFG_PAL_STEP0 : `CFG_NTSC_STEP0;
      1: table_data = pal ? `CFG_PAL_STEP1 : `CFG_NTSC_STEP1;
      2: table_data = pal ? `CFG_PAL_STEP2 : `CFG_NTSC_STEP2;
      3: table_data = pal ? `CFG_PAL_STEP3 : `CFG_NTSC_STEP3;
      4: table_data = pal ? `CFG_PAL_STEP4 : `CFG_NTSC_STEP4;
      5: table_data = pal ? `CFG_PAL_STEP5 : `CFG_NTSC_STEP5;
      6: table_data = pal ? `CFG_PAL_STEP6 : `CFG_NTSC_STEP6;
      default: table_data = pal ? `CFG_PAL_STEP7 : `CFG_NTSC_STEP7;
    endcase
  endfunction

  // random upper bits with the region code in the low bits
  function automatic bridge_data_t region_word(input logic pal);
    bridge_data_t data;
    data = $urandom;
    data[1:0] = pal ? $urandom_range(1, 3) : 0;
    return data;
  endfunction

  task automatic model_write(input bridge_addr_t addr, input bridge_data_t data);
    case (addr)
      `ADDR_REGION:        m_region = region_t'(data);
      `ADDR_HIDE_OVERSCAN: m_hide = data[0];
      `ADDR_MASK_EDGES:    m_mask = edge_mask_t'(data);
      `ADDR_EXTRA_SPRITES: m_sprites = data[0];
      `ADDR_PALETTE:       m_palette = palette_t'(data);
      `ADDR_MULTITAP:      m_multitap = data[0];
      `ADDR_LIGHTGUN:      m_lightgun = data[0];
      `ADDR_AIM_SPEED:     m_aim = aim_speed_t'(data);
      `ADDR_SWAP_CONT:     m_swap = data[0];
      default: ;
    endcase
  endtask

  task automatic check_settings();
    check_value("region", region, m_region);
    check_value("hide_overscan", hide_overscan, m_hide);
    check_value("mask_vid_edges", mask_vid_edges, m_mask);
    check_value("allow_extra_sprites", allow_extra_sprites, m_sprites);
    check_value("selected_palette", selected_palette, m_palette);
    check_value("multitap_enabled", multitap_enabled, m_multitap);
    check_value("lightgun_enabled", lightgun_enabled, m_lightgun);
    check_value("lightgun_aim_speed", lightgun_aim_speed, m_aim);
    check_value("swap_controllers", swap_controllers, m_swap);
  endtask

  //////////////////////////////////////////////////
  // bus drivers and waits

  task automatic bridge_write(input bridge_addr_t addr, input bridge_data_t data);
    @(negedge clk_74a);
    bridge_addr    = addr;
    bridge_wr_data = data;
    bridge_wr      = 1'b1;
    model_write(addr, data);
    @(negedge clk_74a);
    bridge_wr = 1'b0;
  endtask

  // stalls of 0 to 3 cycles between accepted writes
  task automatic run_responder();
    int stall;
    stall = 0;
    forever begin
      @(negedge clk_74a);
      if (wait_enable && stall > 0) begin
        cfg_waitrequest = 1'b1;
        stall--;
      end else begin
        cfg_waitrequest = 1'b0;
        stall = wait_enable ? $urandom_range(0, 3) : 0;
      end
      @(posedge clk_74a);
      if (cfg_waitrequest) begin
        // no write may be offered while the port is stalled
        check_value("cfg_write", cfg_write, 0);
      end else if (cfg_write) begin
        log_addr.push_back(cfg_address);
        log_data.push_back(cfg_data);
        log_reset.push_back(core_reset);
      end
    end
  endtask

  task automatic clear_log();
    log_addr.delete();
    log_data.delete();
    log_reset.delete();
  endtask

  task automatic wait_writes(input int count, input string what);
    int cycles;
    cycles = 0;
    while (log_addr.size() < count) begin
      @(negedge clk_74a);
      cycles++;
      if (cycles > 400)
        report_timeout(what);
    end
  endtask

  task automatic wait_reset_low(input string what);
    int cycles;
    cycles = 0;
    while (core_reset) begin
      @(negedge clk_74a);
      cycles++;
      if (cycles > 400)
        report_timeout(what);
    end
  endtask

  // whole table for one mode with the core parked from the second write on
  task automatic check_sequence(input logic pal);
    int i;
    check_value("cfg_write count", log_addr.size(), `CFG_STEPS);
    for (i = 0; i < `CFG_STEPS; i++) begin
      check_value("cfg_address", log_addr[i], table_addr(i));
      check_value("cfg_data", log_data[i], table_data(i, pal));
      if (i > 0)
        check_value("core_reset", log_reset[i], 1);
    end
    clear_log();
  endtask

  // cycles counted from the write edge
  task automatic measure_hold(output int rise, output int fall);
    int cycles;
    cycles = 0;
    rise = -1;
    fall = -1;
    while (fall < 0) begin
      @(negedge clk_74a);
      cycles++;
      if (core_reset && rise < 0)
        rise = cycles;
      else if (!core_reset && rise >= 0)
        fall = cycles;
      if (cycles > `SOFT_RESET_CYCLES + 16)
        report_timeout("core_reset did not complete a soft reset hold");
    end
  endtask

  //////////////////////////////////////////////////
  // main sequence

  initial begin
    int i;
    int kind;
    int rise;
    int fall;
    logic pal;
    bridge_addr_t addr;
    void'($urandom(32'h5ea2));
    pll_core_locked = 1'b0;
    bridge_addr     = '0;
    bridge_wr       = 1'b0;
    bridge_wr_data  = '0;
    cfg_waitrequest = 1'b0;
    wait_enable     = 1'b0;
    {m_region, m_hide, m_mask, m_sprites, m_palette} = '0;
    {m_multitap, m_lightgun, m_aim, m_swap} = '0;
    repeat (5) @(negedge clk_74a);
    pll_core_locked = 1'b1;
    fork
      run_responder();
    join_none

    // reset state
    @(negedge clk_74a);
    check_settings();
    check_value("core_reset", core_reset, 0);
    check_value("cfg_write", cfg_write, 0);

    // random settings writes to valid and near-miss addresses
    wait_enable = 1'b1;
    for (i = 0; i < 200; i++) begin
      kind = $urandom_range(0, 3);
      if (kind < 2)
        addr = setting_addr($urandom_range(0, 8));
      else if (kind == 2)
        addr = $urandom;
      else
        addr = setting_addr($urandom_range(0, 8)) ^ (32'd1 << $urandom_range(0, 31));
      if (addr == `ADDR_SOFT_RESET)
        addr = addr ^ 32'h8000_0000;
      bridge_write(addr, $urandom);
      check_settings();
    end
    repeat (4) @(negedge clk_74a);
    wait_reset_low("core_reset never fell after the settings writes");
    clear_log();

    // region switches where every third write keeps the mode
    for (i = 0; i < 12; i++) begin
      pal = m_region != '0;
      if (i % 3 != 2)
        pal = !pal;
      bridge_write(`ADDR_REGION, region_word(pal));
      check_settings();
      if (i % 3 != 2) begin
        wait_writes(`CFG_STEPS, "PLL management writes never completed");
        wait_reset_low("core_reset never fell after reconfiguration");
        check_sequence(pal);
      end else begin
        repeat (16) @(negedge clk_74a);
        check_value("cfg_write count", log_addr.size(), 0);
        check_value("core_reset", core_reset, 0);
      end
    end

    // mode flipped back while a sequence is running
    for (i = 0; i < 4; i++) begin
      pal = m_region == '0;
      bridge_write(`ADDR_REGION, region_word(pal));
      wait_writes(3, "first PLL management writes never came");
      pal = !pal;
      bridge_write(`ADDR_REGION, region_word(pal));
      // old writes can still land until the mode compare sees the change
      repeat (2) @(negedge clk_74a);
      clear_log();
      wait_writes(`CFG_STEPS, "restarted PLL sequence never completed");
      wait_reset_low("core_reset never fell after the restarted sequence");
      check_sequence(pal);
    end

    // soft reset hold and then a second request halfway through
    wait_enable = 1'b0;
    bridge_write(`ADDR_SOFT_RESET, $urandom);
    measure_hold(rise, fall);
    check_value("core_reset rise cycle", rise, 2);
    check_value("core_reset fall cycle", fall, `SOFT_RESET_CYCLES + 2);
    bridge_write(`ADDR_SOFT_RESET, $urandom);
    for (i = 1; i <= `SOFT_RESET_CYCLES / 2; i++) begin
      @(negedge clk_74a);
      if (i >= 2)
        check_value("core_reset", core_reset, 1);
    end
    bridge_write(`ADDR_SOFT_RESET, $urandom);
    measure_hold(rise, fall);
    check_value("core_reset rise cycle", rise, 1);
    check_value("core_reset fall cycle", fall, `SOFT_RESET_CYCLES + 2);
    check_value("cfg_write count", log_addr.size(), 0);
    check_settings();

    $display("Simulation passed");
    $finish;
  end

endmodule

//--- verilog.f
+incdir+common
common/nes_core_pkg.sv
settings/settings_regs.sv
pll_reconfig/pll_reconfig_seq.sv
source/core_reset_ctrl.sv
source/core_control_top.sv
tb/tb_core_control.sv
